// File: src/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// deck value after reset.
`define LFSR_SEED 5'b11100

// keypad code that ends player 1's turn.
`define KEY_END_P1 4'b0011

// keypad code that ends player 2's turn.
`define KEY_END_P2 4'b0001

// the consumer has this many buffer slots, so the emitter starts with as many credits.
`define CREDIT_MAX 4

// the event_emitter card queue has this many entries and must be a power of two.
`define QUEUE_DEPTH 4

`endif

// File: src/game_pkg.sv
`default_nettype none

// Player identity shared by the turn logic and the card path.
package game_pkg;

    // one bit is enough for the two seats at the table.
    typedef enum logic {
        player_1 = 1'b0,
        player_2 = 1'b1
    } player_t;

endpackage : game_pkg

`default_nettype wire

// File: src/card_pkg.sv
`default_nettype none

// Card encodings for the deck and the card outputs.
package card_pkg;

    localparam int color_w  = 2; // the color output holds values 1 to 3.
    localparam int number_w = 3; // the number output holds values 0 to 4.

    // the deck word read as card fields with the color in the upper bits.
    typedef struct packed {
        logic [color_w-1:0]  color_bits;
        logic [number_w-1:0] number_bits;
    } card_fields_t;

    // one word is read in two ways.
    // the LFSR shifts through raw and the card is decoded from fields.
    typedef union packed {
        logic [color_w+number_w-1:0] raw;
        card_fields_t                fields;
    } deck_word_u;

endpackage : card_pkg

`default_nettype wire

// File: src/turn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

// Two-state turn machine. The player whose turn it is ends it with
// their own keypad code, which also requests one card flip.
module turn_ctrl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [3:0]        keypad,
    input  wire logic              ready,
    output game_pkg::player_t      turn,
    output logic                   flip,
    output game_pkg::player_t      flip_player
);

    logic              key_match;
    game_pkg::player_t other_player;

    // only the current player's own code counts.
    always_comb begin
        key_match = 1'b0;
        if (turn == game_pkg::player_1) begin
            key_match = (keypad == `KEY_END_P1);
        end else begin
            key_match = (keypad == `KEY_END_P2);
        end
    end

    assign other_player = (turn == game_pkg::player_1) ? game_pkg::player_2
                                                       : game_pkg::player_1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            turn        <= game_pkg::player_1;
            flip        <= 1'b0;
            flip_player <= game_pkg::player_1;
        end else begin
            flip <= key_match && ready; // a single-cycle pulse per accepted key.
            if (key_match && ready) begin
                flip_player <= turn;
                turn        <= other_player;
            end
        end
    end

endmodule : turn_ctrl

`default_nettype wire

// File: src/card_deck.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

// Pseudo-random deck. Each flip takes the card under the current LFSR
// value, stamps it with the flip count and then steps the LFSR once.
module card_deck (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          flip,
    input  wire game_pkg::player_t             flip_player,
    output logic                               card_push,
    output game_pkg::player_t                  card_player,
    output logic [card_pkg::color_w-1:0]       card_color,
    output logic [card_pkg::number_w-1:0]      card_number,
    output logic [7:0]                         card_seq
);

    card_pkg::deck_word_u                  deck;
    logic [7:0]                            flip_cnt;
    logic [card_pkg::color_w-1:0]          color_d;
    logic [card_pkg::number_w-1:0]         number_d;

    // color folds 0..3 onto 1..3 and number folds 0..7 onto 0..4.
    assign color_d  = deck.fields.color_bits % 2'd3 + 2'd1;
    assign number_d = deck.fields.number_bits % 3'd5;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            deck.raw  <= `LFSR_SEED;
            flip_cnt  <= 8'd0;
            card_push <= 1'b0;
        end else begin
            card_push <= flip;
            if (flip) begin
                // shift left with taps on bits 4 and 2.
                deck.raw <= {deck.raw[3:0], deck.raw[2] ^ deck.raw[4]};
                flip_cnt <= flip_cnt + 8'd1; // wraps at 256.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flip) begin
            card_player <= flip_player;
            card_color  <= color_d;
            card_number <= number_d;
            card_seq    <= flip_cnt;
        end
    end

endmodule : card_deck

`default_nettype wire

// File: src/event_emitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

// Card queue in front of a credit-controlled consumer.
// One card leaves per cycle while the queue holds cards and a credit is left.
module event_emitter (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          card_push,
    input  wire game_pkg::player_t             card_player,
    input  wire logic [card_pkg::color_w-1:0]  card_color,
    input  wire logic [card_pkg::number_w-1:0] card_number,
    input  wire logic [7:0]                    card_seq,
    input  wire logic                          credit_return,
    output logic                               ready,
    output logic                               card_valid,
    output game_pkg::player_t                  out_player,
    output logic [card_pkg::color_w-1:0]       out_color,
    output logic [card_pkg::number_w-1:0]      out_number,
    output logic [7:0]                         out_seq
);

    localparam int depth   = `QUEUE_DEPTH;
    localparam int ptr_w   = $clog2(depth);
    localparam int cnt_w   = $clog2(depth + 1);
    localparam int cred_w  = $clog2(`CREDIT_MAX + 1);
    localparam int entry_w = 1 + card_pkg::color_w + card_pkg::number_w + 8;

    logic [entry_w-1:0] queue_mem [depth];
    logic [entry_w-1:0] head;
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   q_count;
    logic [cnt_w:0]     q_used;
    logic [cred_w-1:0]  credits;
    logic               credit_ok;
    logic               pop;

    // the beat on card_valid right now still holds one credit.
    assign credit_ok = credits > {{(cred_w-1){1'b0}}, card_valid};
    assign pop       = (q_count != '0) && credit_ok;

    // a slot is also kept for a flip that card_deck may already be working on.
    assign q_used = {1'b0, q_count} + {{cnt_w{1'b0}}, card_push};
    assign ready  = q_used <= (cnt_w + 1)'(depth - 2);

    assign head = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (card_push) begin
            queue_mem[wr_ptr] <= {card_player, card_color, card_number, card_seq};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            credits    <= cred_w'(`CREDIT_MAX);
            card_valid <= 1'b0;
        end else begin
            card_valid <= pop;
            if (card_push) wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({card_push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // a beat and a return in the same cycle cancel out.
            case ({card_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_player <= game_pkg::player_t'(head[entry_w-1]);
            out_color  <= head[entry_w-2 -: card_pkg::color_w];
            out_number <= head[8 +: card_pkg::number_w];
            out_seq    <= head[7:0];
        end
    end

endmodule : event_emitter

`default_nettype wire

// File: src/card_table_top.sv
`timescale 1ns/1ps
`default_nettype none

// Card table: keypad turn control, deck, and credit-based card output.
module card_table_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [3:0]                    keypad,
    input  wire logic                          credit_return,
    output game_pkg::player_t                  turn,
    output logic                               card_valid,
    output game_pkg::player_t                  card_player,
    output logic [card_pkg::color_w-1:0]       card_color,
    output logic [card_pkg::number_w-1:0]      card_number,
    output logic [7:0]                         card_seq
);

    logic                              ready;
    logic                              flip;
    game_pkg::player_t                 flip_player;
    logic                              deck_push;
    game_pkg::player_t                 deck_player;
    logic [card_pkg::color_w-1:0]      deck_color;
    logic [card_pkg::number_w-1:0]     deck_number;
    logic [7:0]                        deck_seq;

    turn_ctrl u_turn_ctrl (
        .clk         (clk),
        .rst         (rst),
        .keypad      (keypad),
        .ready       (ready),
        .turn        (turn),
        .flip        (flip),
        .flip_player (flip_player)
    );

    card_deck u_card_deck (
        .clk         (clk),
        .rst         (rst),
        .flip        (flip),
        .flip_player (flip_player),
        .card_push   (deck_push),
        .card_player (deck_player),
        .card_color  (deck_color),
        .card_number (deck_number),
        .card_seq    (deck_seq)
    );

    event_emitter u_event_emitter (
        .clk           (clk),
        .rst           (rst),
        .card_push     (deck_push),
        .card_player   (deck_player),
        .card_color    (deck_color),
        .card_number   (deck_number),
        .card_seq      (deck_seq),
        .credit_return (credit_return),
        .ready         (ready),
        .card_valid    (card_valid),
        .out_player    (card_player),
        .out_color     (card_color),
        .out_number    (card_number),
        .out_seq       (card_seq)
    );

endmodule : card_table_top

`default_nettype wire

// File: tests/card_table_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

// Protocol checks on the card queue and the credit counter of event_emitter.
module card_table_assertions (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire logic                                  card_push,
    input  wire logic                                  card_valid,
    input  wire logic [$clog2(`CREDIT_MAX + 1)-1:0]    credits,
    input  wire logic [$clog2(`QUEUE_DEPTH + 1)-1:0]   q_count,
    input  wire logic [card_pkg::color_w-1:0]          out_color,
    input  wire logic [card_pkg::number_w-1:0]         out_number
);

    localparam int cred_w = $clog2(`CREDIT_MAX + 1);
    localparam int cnt_w  = $clog2(`QUEUE_DEPTH + 1);

    int failures = 0; // read by the testbench at the end of the run.

    valid_low_in_reset: assert property (@(posedge clk) !rst |-> !card_valid)
        else begin
            failures++;
            $error("card_valid is high while reset is asserted");
        end

    beat_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        card_valid |-> credits != '0)
        else begin
            failures++;
            $error("card_valid beat sent with no credit left");
        end

    credit_in_range: assert property (@(posedge clk) disable iff (!rst)
        credits <= cred_w'(`CREDIT_MAX))
        else begin
            failures++;
            $error("credit count is above the consumer buffer size");
        end

    // a card written into a full queue would be lost.
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst)
        card_push |-> q_count < cnt_w'(`QUEUE_DEPTH))
        else begin
            failures++;
            $error("card pushed into a full queue");
        end

    card_in_range: assert property (@(posedge clk) disable iff (!rst)
        card_valid |-> (out_color != '0) && (out_number <= 3'd4))
        else begin
            failures++;
            $error("card color or number out of range");
        end

endmodule : card_table_assertions

bind event_emitter card_table_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .card_push  (card_push),
    .card_valid (card_valid),
    .credits    (credits),
    .q_count    (q_count),
    .out_color  (out_color),
    .out_number (out_number)
);

`default_nettype wire

// File: tests/card_table_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module card_table_tb;

    localparam int max_cycles = 3000; // about twice the length of the stimulus.
    localparam logic [3:0] idle_key = 4'hF;

    logic                          clk = 1'b0;
    logic                          rst;
    logic [3:0]                    keypad;
    logic                          credit_return;
    game_pkg::player_t             turn;
    logic                          card_valid;
    game_pkg::player_t             card_player;
    logic [card_pkg::color_w-1:0]  card_color;
    logic [card_pkg::number_w-1:0] card_number;
    logic [7:0]                    card_seq;

    // reference model of the table, stepped once per rising edge.
    game_pkg::player_t             m_turn = game_pkg::player_1;
    card_pkg::deck_word_u          m_deck;
    // a key was accepted and its card is not decoded yet.
    bit                            m_at_flip = 1'b0;
    // the card is decoded and on its way to the queue.
    bit                            m_at_push = 1'b0;
    bit                            m_valid = 1'b0;
    int                            m_queued = 0;
    int                            m_outstanding = 0; // beats not yet paid back.
    int                            m_flips = 0;
    game_pkg::player_t             exp_player[$];
    logic [card_pkg::color_w-1:0]  exp_color[$];
    logic [card_pkg::number_w-1:0] exp_number[$];
    logic [7:0]                    exp_seq[$];

    int held = 0; // beats the consumer has received and not returned.
    int cards_seen = 0;
    int errors = 0;
    int cycles = 0;

    card_table_top UUT (
        .clk           (clk),
        .rst           (rst),
        .keypad        (keypad),
        .credit_return (credit_return),
        .turn          (turn),
        .card_valid    (card_valid),
        .card_player   (card_player),
        .card_color    (card_color),
        .card_number   (card_number),
        .card_seq      (card_seq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    endtask

    function automatic logic [3:0] own_key();
        return (m_turn == game_pkg::player_1) ? `KEY_END_P1 : `KEY_END_P2;
    endfunction

    function automatic logic [3:0] other_key();
        return (m_turn == game_pkg::player_1) ? `KEY_END_P2 : `KEY_END_P1;
    endfunction

    task automatic score_edge();
        bit key_ok;
        bit accept;
        bit pop;
        int color_val;
        int number_val;
        key_ok = (m_turn == game_pkg::player_1) ? (keypad == `KEY_END_P1)
                                                : (keypad == `KEY_END_P2);
        // room must cover the queue and the card one stage before it.
        accept = key_ok && (m_queued + int'(m_at_push) <= `QUEUE_DEPTH - 2);
        pop = (m_queued > 0) && (m_outstanding < `CREDIT_MAX);
        m_outstanding = m_outstanding + int'(pop) - int'(credit_return);
        m_queued = m_queued + int'(m_at_push) - int'(pop);
        m_at_push = m_at_flip;
        m_at_flip = accept;
        m_valid = pop;
        if (accept) begin
            color_val = int'(m_deck.fields.color_bits) % 3 + 1;
            number_val = int'(m_deck.fields.number_bits) % 5;
            exp_player.push_back(m_turn);
            exp_color.push_back(color_val[card_pkg::color_w-1:0]);
            exp_number.push_back(number_val[card_pkg::number_w-1:0]);
            exp_seq.push_back(m_flips[7:0]);
            m_flips++;
            m_deck.raw = {m_deck.raw[3:0], m_deck.raw[2] ^ m_deck.raw[4]};
            m_turn = (m_turn == game_pkg::player_1) ? game_pkg::player_2 : game_pkg::player_1;
        end
        if (turn !== m_turn) mismatch("turn", int'(m_turn), int'(turn));
        if (card_valid !== m_valid) mismatch("card_valid", int'(m_valid), int'(card_valid));
        if (m_valid) begin
            held++;
            cards_seen++;
            if (card_player !== exp_player[0])
                mismatch("card_player", int'(exp_player[0]), int'(card_player));
            if (card_color !== exp_color[0])
                mismatch("card_color", int'(exp_color[0]), int'(card_color));
            if (card_number !== exp_number[0])
                mismatch("card_number", int'(exp_number[0]), int'(card_number));
            if (card_seq !== exp_seq[0]) mismatch("card_seq", int'(exp_seq[0]), int'(card_seq));
            void'(exp_player.pop_front());
            void'(exp_color.pop_front());
            void'(exp_number.pop_front());
            void'(exp_seq.pop_front());
        end
    endtask

    // outputs are settled 1 ns after the edge and inputs only move at 2 ns.
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            if (card_valid !== 1'b0) mismatch("card_valid", 0, int'(card_valid));
            if (turn !== game_pkg::player_1) mismatch("turn", 0, int'(turn));
        end else begin
            score_edge();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive(input logic [3:0] key, input int return_pct);
        keypad = key;
        credit_return = 1'b0;
        if (held > 0 && int'($urandom % 100) < return_pct) begin
            credit_return = 1'b1;
            held--;
        end
    endtask

    task automatic step(input logic [3:0] key, input int return_pct);
        next_cycle();
        drive(key, return_pct);
    endtask

    // the key is picked after the edge so that a turn change there is already seen.
    task automatic press_own_key(input int return_pct);
        next_cycle();
        drive(own_key(), return_pct);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_seq.size() != 0 || held != 0) && waited < 60) begin
            step(idle_key, 100);
            waited++;
        end
        if (exp_seq.size() != 0 || held != 0) begin
            errors++;
            $display("cards or credits still outstanding after %0d idle cycles", waited);
        end
    endtask

    task automatic measure_latency();
        int edges;
        edges = 0;
        press_own_key(0);
        step(idle_key, 0); // the key has been sampled by now.
        while (!card_valid && edges < 8) begin
            step(idle_key, 0);
            edges++;
        end
        if (edges != 3) mismatch("card_valid latency", 3, edges);
    endtask

    task automatic hold_credits();
        int beats_before;
        int flips_before;
        beats_before = cards_seen;
        flips_before = m_flips;
        repeat (20) press_own_key(0);
        if (cards_seen - beats_before != `CREDIT_MAX)
            mismatch("card_valid beats", `CREDIT_MAX, cards_seen - beats_before);
        // the consumer buffer and the queue take this many cards and later keys are refused.
        if (m_flips - flips_before != `CREDIT_MAX + `QUEUE_DEPTH)
            mismatch("accepted keys", `CREDIT_MAX + `QUEUE_DEPTH, m_flips - flips_before);
    endtask

    task automatic random_run(input int n);
        int pick;
        logic [3:0] key;
        repeat (n) begin
            next_cycle();
            pick = int'($urandom % 10);
            if (pick < 6) key = own_key();
            else if (pick < 8) key = other_key();
            else key = 4'($urandom);
            drive(key, 50);
        end
    endtask

    initial begin
        void'($urandom(32'h7a3c_a130));
        m_deck.raw = `LFSR_SEED;
        rst = 1'b0;
        keypad = idle_key;
        credit_return = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;
        measure_latency();
        drain();
        repeat (4) begin
            step(other_key(), 100);
            step(4'h0, 100);
            press_own_key(100);
            step(idle_key, 100);
        end
        drain();
        hold_credits();
        drain();
        repeat (300) press_own_key(100); // long enough for card_seq to wrap.
        drain();
        random_run(1000);
        drain();
        if (m_flips <= 256) begin
            errors++;
            $display("only %0d cards flipped, card_seq never wrapped", m_flips);
        end
        $display("done: %0d errors, %0d assertion failures, %0d cards checked, %0d cycles",
                 errors, UUT.u_event_emitter.u_assertions.failures, cards_seen, cycles);
        if (errors == 0 && UUT.u_event_emitter.u_assertions.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : card_table_tb

`default_nettype wire

// File: flist.f
+incdir+src
src/game_pkg.sv
src/card_pkg.sv
src/turn_ctrl.sv
src/card_deck.sv
src/event_emitter.sv
src/card_table_top.sv
tests/card_table_assertions.sv
tests/card_table_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log.
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module card_table_tb -f flist.f -o card_table_sim &&
./obj_dir/card_table_sim +verilator+error+limit+100 2>&1 | tee sim.log &&
grep -q "^TESTBENCH PASSED$" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
